//--- src/sifh_pkg.sv
package sifh_pkg;

    localparam int pixel_num         = 4;
    localparam int bin_num           = 16;
    localparam int bin_w             = $clog2(bin_num);
    localparam int pixel_w           = $clog2(pixel_num);
    localparam int time_w            = 8;
    localparam int count_w           = 8;   // saturates at 255
    localparam int acq_w             = 8;
    localparam int samples_per_pixel = 2;
    localparam int smp_w             = $clog2(samples_per_pixel);
    localparam int ram_depth         = pixel_num * bin_num;
    localparam int addr_w            = $clog2(ram_depth);

    localparam int apb_aw = 12;
    localparam int apb_dw = 32;

    localparam logic [apb_aw-1:0] reg_ctrl      = 12'h000;
    localparam logic [apb_aw-1:0] reg_status    = 12'h004;
    localparam logic [apb_aw-1:0] reg_peak_base = 12'h010;
    localparam logic [apb_aw-1:0] reg_hist_base = 12'h100;

    typedef logic [time_w-1:0]  time_t;
    typedef logic [bin_w-1:0]   bin_t;
    typedef logic [count_w-1:0] count_t;
    typedef logic [addr_w-1:0]  ram_addr_t;   // {pixel, bin}
    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [acq_w-1:0]   acq_t;

    typedef enum logic [1:0] {bld_idle, bld_accept, bld_write} build_state_t;
    typedef enum logic [1:0] {pk_idle, pk_clear, pk_wait_frame, pk_scan} peak_state_t;

endpackage

//--- src/hist_ram.sv
`timescale 1ns/1ps

module hist_ram
    import sifh_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  ram_addr_t addr,
    input  count_t    wdata,
    output count_t    rdata
);

    count_t mem [ram_depth];

    // read returns the old word on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- src/ram_arbiter.sv
`timescale 1ns/1ps

module ram_arbiter
    import sifh_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      bld_req,
    input  logic      bld_we,
    input  ram_addr_t bld_addr,
    input  count_t    bld_wdata,
    output logic      bld_gnt,
    input  logic      pk_req,
    input  logic      pk_we,
    input  ram_addr_t pk_addr,
    input  count_t    pk_wdata,
    output logic      pk_gnt,
    input  logic      apb_req,
    input  logic      apb_we,
    input  ram_addr_t apb_addr,
    input  count_t    apb_wdata,
    output logic      apb_gnt,
    output count_t    rd_data,
    output logic      ram_we,
    output ram_addr_t ram_addr,
    output count_t    ram_wdata,
    input  count_t    ram_rdata
);

    logic   rd_pend;   // a read was granted last cycle
    count_t rd_hold;

    // peak finder > builder > apb
    assign pk_gnt  = pk_req;
    assign bld_gnt = bld_req & ~pk_req;
    assign apb_gnt = apb_req & ~pk_req & ~bld_req;

    always_comb begin
        ram_we    = 1'b0;
        ram_addr  = '0;
        ram_wdata = '0;
        if (pk_gnt) begin
            ram_we    = pk_we;
            ram_addr  = pk_addr;
            ram_wdata = pk_wdata;
        end else if (bld_gnt) begin
            ram_we    = bld_we;
            ram_addr  = bld_addr;
            ram_wdata = bld_wdata;
        end else if (apb_gnt) begin
            ram_we    = apb_we;
            ram_addr  = apb_addr;
            ram_wdata = apb_wdata;
        end
    end

    // hold the last read word until the next granted read
    assign rd_data = rd_pend ? ram_rdata : rd_hold;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= (pk_gnt | bld_gnt | apb_gnt) & ~ram_we;
        end
    end

    always_ff @(posedge clk) begin
        rd_hold <= rd_data;
    end

endmodule

//--- src/hist_builder.sv
`timescale 1ns/1ps

module hist_builder
    import sifh_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      hit_valid,
    input  time_t     hit_time,
    output logic      hit_ready,
    input  logic      build_go,
    input  acq_t      acq_num,
    output logic      frame_done,
    output logic      req,
    output logic      we,
    output ram_addr_t addr,
    output count_t    wdata,
    input  logic      gnt,
    input  count_t    rd_data
);

    build_state_t     state;
    logic [smp_w-1:0] in_cnt;
    pixel_t           pix_cnt;
    acq_t             acq_cnt;
    ram_addr_t        wr_addr;
    bin_t             hit_bin;
    logic             last_in;
    logic             last_pix;
    logic             last_acq;

    assign hit_bin  = hit_time[time_w-1 -: bin_w];
    assign last_in  = in_cnt == smp_w'(samples_per_pixel - 1);
    assign last_pix = pix_cnt == pixel_t'(pixel_num - 1);
    assign last_acq = acq_cnt == acq_num - 8'd1;

    // read is issued together with the accept, write follows
    assign req       = (state == bld_accept) ? hit_valid : (state == bld_write);
    assign we        = state == bld_write;
    assign addr      = (state == bld_write) ? wr_addr : {pix_cnt, hit_bin};
    assign wdata     = (rd_data == '1) ? rd_data : rd_data + 1'b1;   // saturate
    assign hit_ready = (state == bld_accept) & gnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= bld_idle;
            in_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                bld_idle: begin
                    if (build_go) begin
                        state   <= bld_accept;
                        in_cnt  <= '0;
                        pix_cnt <= '0;
                        acq_cnt <= '0;
                    end
                end
                bld_accept: begin
                    if (hit_ready) begin
                        state <= bld_write;
                    end
                end
                bld_write: begin
                    if (gnt) begin
                        state  <= bld_accept;
                        in_cnt <= last_in ? '0 : in_cnt + 1'b1;
                        if (last_in) begin
                            pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                            if (last_pix) begin
                                acq_cnt <= acq_cnt + 1'b1;
                                if (last_acq) begin
                                    state      <= bld_idle;
                                    frame_done <= 1'b1;
                                end
                            end
                        end
                    end
                end
                default: state <= bld_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hit_ready) begin
            wr_addr <= addr;
        end
    end

endmodule

//--- src/peak_finder.sv
`timescale 1ns/1ps

module peak_finder
    import sifh_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      start,
    output logic      build_go,
    input  logic      frame_done,
    output logic      scan_done,
    output logic      req,
    output logic      we,
    output ram_addr_t addr,
    output count_t    wdata,
    input  logic      gnt,
    input  count_t    rd_data,
    output logic      peak_valid,
    output pixel_t    peak_pixel,
    output bin_t      peak_bin,
    output count_t    peak_count
);

    peak_state_t state;
    ram_addr_t   cnt;        // clear / scan address
    logic        issuing;    // scan reads left to issue
    logic        vld;        // rd_data holds a scan word
    ram_addr_t   vld_addr;
    count_t      max_cnt;
    bin_t        max_bin;
    bin_t        vld_bin;
    pixel_t      vld_pix;
    logic        higher;
    count_t      new_cnt;
    bin_t        new_bin;

    assign vld_bin = vld_addr[bin_w-1:0];
    assign vld_pix = vld_addr[addr_w-1:bin_w];
    assign higher  = (vld_bin == '0) || (rd_data > max_cnt);   // ties keep lower bin
    assign new_cnt = higher ? rd_data : max_cnt;
    assign new_bin = higher ? vld_bin : max_bin;

    always_comb begin
        req   = 1'b0;
        we    = 1'b0;
        addr  = cnt;
        wdata = '0;
        case (state)
            pk_clear: begin
                req = 1'b1;
                we  = 1'b1;
            end
            pk_wait_frame: begin
                req  = frame_done;   // first scan read in the frame_done cycle
                addr = '0;
            end
            pk_scan: req = issuing;
            default: req = 1'b0;
        endcase
    end

    assign build_go = (state == pk_clear) & gnt & (cnt == ram_addr_t'(ram_depth - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= pk_idle;
            cnt        <= '0;
            issuing    <= 1'b0;
            vld        <= 1'b0;
            peak_valid <= 1'b0;
            scan_done  <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            scan_done  <= 1'b0;
            vld        <= req & gnt & ~we;
            case (state)
                pk_idle: begin
                    if (start) begin
                        state <= pk_clear;
                        cnt   <= '0;
                    end
                end
                pk_clear: begin
                    if (gnt) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (build_go) begin
                        state <= pk_wait_frame;
                    end
                end
                pk_wait_frame: begin
                    if (frame_done && gnt) begin
                        state   <= pk_scan;
                        cnt     <= ram_addr_t'(1);
                        issuing <= 1'b1;
                    end
                end
                pk_scan: begin
                    if (issuing && gnt) begin
                        cnt     <= cnt + 1'b1;
                        issuing <= cnt != '1;
                    end
                    if (vld && vld_bin == '1) begin
                        peak_valid <= 1'b1;
                        if (vld_pix == '1) begin
                            scan_done <= 1'b1;
                            state     <= pk_idle;
                        end
                    end
                end
                default: state <= pk_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        vld_addr <= addr;
        if (vld) begin
            max_cnt <= new_cnt;
            max_bin <= new_bin;
        end
        if (vld && vld_bin == '1) begin
            peak_pixel <= vld_pix;
            peak_bin   <= new_bin;
            peak_count <= new_cnt;
        end
    end

endmodule

//--- src/sifh_apb_regs.sv
`timescale 1ns/1ps

module sifh_apb_regs
    import sifh_pkg::*;
(
    input  logic              clk,
    input  logic              res,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [apb_dw-1:0] pwdata,
    output logic [apb_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              start,
    output acq_t              acq_num,
    input  logic              peak_valid,
    input  pixel_t            peak_pixel,
    input  bin_t              peak_bin,
    input  count_t            peak_count,
    input  logic              scan_done,
    output logic              done,
    output logic              req,
    output logic              we,
    output ram_addr_t         addr,
    output count_t            wdata,
    input  logic              gnt,
    input  count_t            rd_data
);

    logic   busy;
    logic   hist_ack;   // RAM word is on rd_data
    logic   access;
    logic   sel_ctrl;
    logic   sel_status;
    logic   sel_peak;
    logic   sel_hist;
    logic   hist_rd;
    logic   mapped;
    pixel_t peak_sel;
    bin_t   peak_bin_q [pixel_num];
    count_t peak_cnt_q [pixel_num];

    assign access     = psel & penable;
    assign sel_ctrl   = paddr == reg_ctrl;
    assign sel_status = paddr == reg_status;
    assign sel_peak   = paddr[apb_aw-1:4] == reg_peak_base[apb_aw-1:4];
    assign sel_hist   = paddr[apb_aw-1:8] == reg_hist_base[apb_aw-1:8];
    assign hist_rd    = access & sel_hist & ~pwrite;
    assign peak_sel   = paddr[pixel_w+1:2];
    assign mapped     = sel_ctrl | (~pwrite & (sel_status | sel_peak | sel_hist));

    // raw bin reads only, never writes
    assign req   = hist_rd & ~hist_ack;
    assign we    = 1'b0;
    assign addr  = paddr[addr_w+1:2];
    assign wdata = '0;

    assign pready  = access & (~hist_rd | hist_ack);
    assign pslverr = pready & ~mapped;

    always_comb begin
        prdata = '0;
        if (hist_ack) begin
            prdata[count_w-1:0] = rd_data;
        end else if (sel_ctrl) begin
            prdata[8 +: acq_w] = acq_num;
        end else if (sel_status) begin
            prdata[1:0] = {done, busy};
        end else if (sel_peak) begin
            prdata[bin_w-1:0]    = peak_bin_q[peak_sel];
            prdata[8 +: count_w] = peak_cnt_q[peak_sel];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            start    <= 1'b0;
            acq_num  <= 8'd1;
            busy     <= 1'b0;
            done     <= 1'b0;
            hist_ack <= 1'b0;
        end else begin
            start    <= 1'b0;
            hist_ack <= hist_rd & gnt & ~hist_ack;
            if (access && pwrite && sel_ctrl && !busy) begin   // ignored while busy
                acq_num <= pwdata[8 +: acq_w];
                start   <= pwdata[0];
            end
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (scan_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (peak_valid) begin
            peak_bin_q[peak_pixel] <= peak_bin;
            peak_cnt_q[peak_pixel] <= peak_count;
        end
    end

endmodule

//--- src/sifh_top.sv
`timescale 1ns/1ps

module sifh_top
    import sifh_pkg::*;
(
    input  logic              clk,
    input  logic              res,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_aw-1:0] paddr,
    input  logic [apb_dw-1:0] pwdata,
    output logic [apb_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              hit_valid,
    input  time_t             hit_time,
    output logic              hit_ready,
    output logic              done
);

    logic      bld_req, bld_we, bld_gnt;
    ram_addr_t bld_addr;
    count_t    bld_wdata;
    logic      pk_req, pk_we, pk_gnt;
    ram_addr_t pk_addr;
    count_t    pk_wdata;
    logic      apb_req, apb_we, apb_gnt;
    ram_addr_t apb_addr;
    count_t    apb_wdata;
    count_t    rd_data;
    logic      ram_we;
    ram_addr_t ram_addr;
    count_t    ram_wdata, ram_rdata;
    logic      start, build_go, frame_done, scan_done;
    acq_t      acq_num;
    logic      peak_valid;
    pixel_t    peak_pixel;
    bin_t      peak_bin;
    count_t    peak_count;

    hist_ram i_ram (
        .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    ram_arbiter i_arb (
        .clk, .res,
        .bld_req, .bld_we, .bld_addr, .bld_wdata, .bld_gnt,
        .pk_req, .pk_we, .pk_addr, .pk_wdata, .pk_gnt,
        .apb_req, .apb_we, .apb_addr, .apb_wdata, .apb_gnt,
        .rd_data, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    hist_builder i_bld (
        .clk, .res, .hit_valid, .hit_time, .hit_ready, .build_go, .acq_num, .frame_done,
        .req(bld_req), .we(bld_we), .addr(bld_addr), .wdata(bld_wdata),
        .gnt(bld_gnt), .rd_data
    );

    peak_finder i_pk (
        .clk, .res, .start, .build_go, .frame_done, .scan_done,
        .req(pk_req), .we(pk_we), .addr(pk_addr), .wdata(pk_wdata),
        .gnt(pk_gnt), .rd_data,
        .peak_valid, .peak_pixel, .peak_bin, .peak_count
    );

    sifh_apb_regs i_regs (
        .clk, .res, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .start, .acq_num, .peak_valid, .peak_pixel, .peak_bin, .peak_count, .scan_done, .done,
        .req(apb_req), .we(apb_we), .addr(apb_addr), .wdata(apb_wdata),
        .gnt(apb_gnt), .rd_data
    );

endmodule

//--- tests/tb_sifh.sv
`timescale 1ns/1ps

module tb_sifh
    import sifh_pkg::*;
();

    localparam logic [7:0] pat_random = 8'd0;
    localparam logic [7:0] pat_forced = 8'd1;   // every sample lands in bin 9
    localparam logic [7:0] pat_tie    = 8'd2;   // bins 11 and 5 end up equal
    localparam int         row_num    = 4;

    // each row holds acq_num, pattern and idle gaps
    localparam logic [0:row_num-1][23:0] frame_tab = {
        {8'd3,   pat_random, 8'd5},
        {8'd6,   pat_tie,    8'd0},
        {8'd255, pat_forced, 8'd0},
        {8'd10,  pat_random, 8'd20}
    };

    logic              clk;
    logic              res;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [apb_aw-1:0] paddr;
    logic [apb_dw-1:0] pwdata;
    logic [apb_dw-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              hit_valid;
    time_t             hit_time;
    logic              hit_ready;
    logic              done;
    int                model [pixel_num][bin_num];
    int                seed;

    sifh_top i_dut (
        .clk, .res, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .hit_valid, .hit_time, .hit_ready, .done
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // one APB transfer, called 10 ns after a rising edge
    task automatic bus_xfer(input logic wr, input logic [apb_aw-1:0] a,
                            input logic [apb_dw-1:0] wd,
                            output logic [apb_dw-1:0] rd, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = wd;
        idle_cycles(1);
        penable = 1'b1;
        do @(negedge clk); while (!pready);
        rd  = prdata;
        err = pslverr;
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [apb_aw-1:0] a, input logic [apb_dw-1:0] wd);
        logic [apb_dw-1:0] rd;
        logic              err;
        bus_xfer(1'b1, a, wd, rd, err);
        expect_eq("pslverr", err, 0);
    endtask

    task automatic read_reg(input logic [apb_aw-1:0] a, output logic [apb_dw-1:0] rd);
        logic err;
        bus_xfer(1'b0, a, '0, rd, err);
        expect_eq("pslverr", err, 0);
    endtask

    // hit_valid stays high until the DUT takes the sample
    task automatic send_hit(input time_t t);
        hit_valid = 1'b1;
        hit_time  = t;
        do @(negedge clk); while (!hit_ready);
        @(posedge clk);
        #10;
        hit_valid = 1'b0;
    endtask

    // highest count wins, lowest bin on ties
    task automatic find_peak(input int p, output int pb, output int pc);
        int b;
        pb = 0;
        pc = model[p][0];
        for (b = 1; b < bin_num; b++) begin
            if (model[p][b] > pc) begin
                pb = b;
                pc = model[p][b];
            end
        end
    endtask

    task automatic run_frame(input int row);
        acq_t              acq;
        logic [7:0]        kind;
        int                gaps;
        int                i;
        int                k;
        int                pix;
        int                bin;
        int                pb;
        int                pc;
        time_t             t;
        logic [apb_dw-1:0] rd;
        acq  = frame_tab[row][23:16];
        kind = frame_tab[row][15:8];
        gaps = frame_tab[row][7:0];
        for (i = 0; i < ram_depth; i++) begin
            model[i / bin_num][i % bin_num] = 0;
        end
        write_reg(reg_ctrl, {16'h0, acq, 8'h01});
        for (k = 0; k < acq * pixel_num * samples_per_pixel; k++) begin
            if (gaps > 0 && k % 2 == 1) begin
                idle_cycles(1 + $urandom % 2);
                gaps--;
            end
            pix = (k / samples_per_pixel) % pixel_num;
            if (kind == pat_forced) begin
                bin = 9;
            end else if (kind == pat_tie) begin
                bin = (k % samples_per_pixel == 0) ? 11 : 5;
            end else begin
                bin = $urandom % bin_num;
            end
            t = time_t'((bin << (time_w - bin_w)) | ($urandom % 16));
            if (model[pix][bin] < 255) begin
                model[pix][bin]++;
            end
            send_hit(t);
        end
        rd = '0;
        while (!rd[1]) begin
            read_reg(reg_status, rd);
        end
        expect_eq("status.busy", rd[0], 0);
        expect_eq("done", done, 1);
        for (i = 0; i < pixel_num; i++) begin
            read_reg(12'(reg_peak_base + 4 * i), rd);
            find_peak(i, pb, pc);
            expect_eq($sformatf("peak_bin[%0d]", i), rd[3:0], pb);
            expect_eq($sformatf("peak_count[%0d]", i), rd[15:8], pc);
            if (kind == pat_tie) begin
                expect_eq($sformatf("peak_bin[%0d] on tie", i), rd[3:0], 5);
            end
            if (kind == pat_forced && acq == 8'd255) begin
                expect_eq($sformatf("peak_count[%0d] saturated", i), rd[15:8], 8'hff);
            end
        end
        for (i = 0; i < ram_depth; i++) begin
            read_reg(12'(reg_hist_base + 4 * i), rd);
            expect_eq($sformatf("hist[%0d]", i), rd, model[i / bin_num][i % bin_num]);
        end
    endtask

    initial begin
        logic [apb_dw-1:0] rd;
        logic              err;
        int                dummy;
        int                r;
        seed      = 22788;
        dummy     = $urandom(seed);
        res       = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        hit_valid = 1'b0;
        hit_time  = '0;
        repeat (2) @(posedge clk);
        #10;
        res = 1'b1;
        @(negedge clk);
        expect_eq("hit_ready", hit_ready, 0);
        expect_eq("done", done, 0);
        expect_eq("pready", pready, 0);
        idle_cycles(1);
        bus_xfer(1'b0, 12'h008, '0, rd, err);
        assert (err)
        else fail_run("read of unmapped address 0x008 returned no slave error");
        read_reg(reg_status, rd);
        expect_eq("status", rd, 0);   // neither busy nor done out of reset
        for (r = 0; r < row_num; r++) begin
            run_frame(r);
        end
        $display("RESULT: PASS");
        $finish;
    end

    // budget of 4 cycles per sample plus clear, scan and readback per frame
    initial begin
        int w;
        int limit;
        limit = 0;
        for (w = 0; w < row_num; w++) begin
            limit += frame_tab[w][23:16] * pixel_num * samples_per_pixel * 4 + 400;
        end
        repeat (limit) @(posedge clk);
        fail_run("timeout, the frame table did not finish in the expected number of cycles");
    end

endmodule

//--- tb.f
src/sifh_pkg.sv
src/hist_ram.sv
src/ram_arbiter.sv
src/hist_builder.sv
src/peak_finder.sv
src/sifh_apb_regs.sv
src/sifh_top.sv
tests/tb_sifh.sv
